// ==== src.f ====
logic/soc_pkg.sv
logic/bus_decoder.sv
logic/irq_priority.sv
logic/boot_rom.sv
logic/scratch_ram.sv
logic/interval_timer.sv
logic/soc_bus_top.sv
tb/soc_bus_properties.sv
tb/bus_checker.sv
tb/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module tb_top -o tb_sim
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^tests failed$" "$LOG"; then
  exit 1
fi

if ! grep -q "^all tests passed$" "$LOG"; then
  echo "no result line in $LOG"
  exit 1
fi
exit 0

// ==== rom_init.hex ====
// one 32-bit ROM word per line, word 0 first
3c1c0001
279c8000
3c1d0001
27bd0ff0
0c000010
00000000
1000ffff
00000000
afbf001c
afbe0018
03a0f021
8fc20000
24420001
afc20000
03e00008
27bd0020

// ==== tb/tb_top.sv ====
module tb_top import soc_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_CYCLES = 8000;

  logic              sysclock = 1'b0;
  logic              rst_i;
  logic              cyc_i;
  logic              we_i;
  logic [SEL_W-1:0]  sel_i;
  logic [ADDR_W-1:0] adr_i;
  logic [DATA_W-1:0] dat_i;
  logic              int_en_i;
  logic [1:0]        ext_irq_i;
  logic [DATA_W-1:0] dat_o;
  logic              ack_o;
  logic              fault_o;
  irq_code_e         irq_code_o;

  int cycles = 0;
  int tests_run = 0;
  int tests_failed = 0;

  soc_bus_top uut (
    .sysclock   (sysclock),
    .rst_i      (rst_i),
    .cyc_i      (cyc_i),
    .we_i       (we_i),
    .sel_i      (sel_i),
    .adr_i      (adr_i),
    .dat_i      (dat_i),
    .int_en_i   (int_en_i),
    .ext_irq_i  (ext_irq_i),
    .dat_o      (dat_o),
    .ack_o      (ack_o),
    .fault_o    (fault_o),
    .irq_code_o (irq_code_o)
  );

  bus_checker chk (
    .sysclock   (sysclock),
    .rst_i      (rst_i),
    .cyc_i      (cyc_i),
    .we_i       (we_i),
    .sel_i      (sel_i),
    .adr_i      (adr_i),
    .dat_i      (dat_i),
    .int_en_i   (int_en_i),
    .ext_irq_i  (ext_irq_i),
    .dat_o      (dat_o),
    .ack_o      (ack_o),
    .fault_o    (fault_o),
    .irq_code_o (irq_code_o)
  );

  always #20 sysclock = ~sysclock;

  always @(posedge sysclock) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: no end of run after %0d clock cycles", MAX_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  // called 2 ns after an edge, returns 2 ns after the edge that samples ack
  task automatic bus_access(input logic we, input logic [SEL_W-1:0] sel,
                            input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] wdata,
                            output logic [DATA_W-1:0] rdata);
    cyc_i = 1'b1;
    we_i  = we;
    sel_i = sel;
    adr_i = adr;
    dat_i = wdata;
    do begin
      @(posedge sysclock);
      #2;
    end while (!ack_o);
    rdata = dat_o;
    // request stays up until the master samples ack
    @(posedge sysclock);
    #2;
    cyc_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge sysclock);
      #2;
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    int errs;
    errs = chk.errors - err_before;
    tests_run++;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  function automatic logic [ADDR_W-1:0] unmapped_addr();
    logic [ADDR_W-1:0] a;
    case ($urandom % 4)
      0: a = {16'($urandom % 16'hffff) + 16'd1, 16'($urandom)};
      1: a = {16'h0, 4'(3 + $urandom % 13), 12'($urandom)};
      2: a = {16'h0, 4'(REGION_ROM), 12'h040 + 12'($urandom % 12'hfc0)};
      default: a = {16'h0, 4'(REGION_TIMER), 12'h020 + 12'($urandom % 12'hfe0)};
    endcase
    return {a[ADDR_W-1:2], 2'b00};
  endfunction

  initial begin
    logic [DATA_W-1:0] rd;
    logic [DATA_W-1:0] cmp;
    int e0;
    int t0;

    void'($urandom(15));
    rst_i     = 1'b1;
    cyc_i     = 1'b0;
    we_i      = 1'b0;
    sel_i     = '0;
    adr_i     = '0;
    dat_i     = '0;
    int_en_i  = 1'b0;
    ext_irq_i = 2'b00;
    repeat (3) @(posedge sysclock);
    #2;
    rst_i = 1'b0;
    idle(1);

    // rom, writes first so the reads show they were dropped
    e0 = chk.errors;
    for (int i = 0; i < 10; i++) begin
      bus_access(1'b1, 4'hf, 32'(($urandom % ROM_WORDS) * 4), $urandom, rd);
    end
    for (int i = 0; i < 100; i++) begin
      bus_access(1'b0, 4'hf, 32'(($urandom % ROM_WORDS) * 4), '0, rd);
    end
    end_test("rom", e0);

    // ram, fill every word so no read sees unknown data
    e0 = chk.errors;
    for (int i = 0; i < RAM_WORDS; i++) begin
      bus_access(1'b1, 4'hf, 32'h1000 + 32'(i * 4), $urandom, rd);
    end
    for (int i = 0; i < 200; i++) begin
      bus_access(1'b1, 4'($urandom), 32'h1000 + 32'(($urandom % RAM_WORDS) * 4), $urandom, rd);
      bus_access(1'b0, 4'hf, 32'h1000 + 32'(($urandom % RAM_WORDS) * 4), '0, rd);
    end
    end_test("ram", e0);

    e0 = chk.errors;
    int_en_i = 1'b1;
    for (int i = 0; i < 50; i++) begin
      ext_irq_i = 2'($urandom);
      bus_access(1'($urandom), 4'hf, unmapped_addr(), $urandom, rd);
    end
    ext_irq_i = 2'b00;
    end_test("unmapped", e0);

    e0 = chk.errors;
    for (int ch = 0; ch < TIMERS; ch++) begin
      cmp = 32'(2 + $urandom % 39);
      bus_access(1'b1, 4'hf, 32'h2000 + 32'(ch * 4), cmp, rd);
      bus_access(1'b0, 4'hf, 32'h2000 + 32'(ch * 4), '0, rd);
      bus_access(1'b1, 4'hf, 32'h2010, 32'(1 << ch), rd);
      t0 = cycles;
      do begin
        bus_access(1'b0, 4'hf, 32'h2014, '0, rd);
      end while (!rd[ch] && (cycles - t0) < 200);
      // polls are two cycles apart
      if (!rd[ch] || (cycles - t0) > int'(cmp) + 3) begin
        chk.note_error($sformatf("timer %0d not pending within %0d cycles", ch, cmp + 2));
      end
      bus_access(1'b1, 4'hf, 32'h2010, '0, rd);
      bus_access(1'b1, 4'hf, 32'h2014, 32'(1 << ch), rd);
      bus_access(1'b0, 4'hf, 32'h2014, '0, rd);
      if (rd[ch]) begin
        chk.note_error($sformatf("timer %0d pending flag not cleared", ch));
      end
    end
    end_test("timer", e0);

    e0 = chk.errors;
    for (int ch = 0; ch < TIMERS; ch++) begin
      bus_access(1'b1, 4'hf, 32'h2000 + 32'(ch * 4), 32'(2 + $urandom % 9), rd);
    end
    for (int i = 0; i < 40; i++) begin
      int_en_i  = 1'($urandom);
      ext_irq_i = 2'($urandom);
      bus_access(1'b1, 4'hf, 32'h2010, 32'($urandom % 16), rd);
      bus_access(1'b1, 4'hf, 32'h2014, 32'($urandom % 16), rd);
      idle($urandom % 16);
    end
    bus_access(1'b1, 4'hf, 32'h2010, '0, rd);
    bus_access(1'b1, 4'hf, 32'h2014, 32'hf, rd);
    end_test("priority", e0);

    $display("%0d tests run, %0d failed, %0d transactions checked, %0d errors",
             tests_run, tests_failed, chk.checks, chk.errors);
    if (tests_failed == 0 && chk.errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== tb/bus_checker.sv ====
module bus_checker import soc_pkg::*; (
  input logic              sysclock,
  input logic              rst_i,
  input logic              cyc_i,
  input logic              we_i,
  input logic [SEL_W-1:0]  sel_i,
  input logic [ADDR_W-1:0] adr_i,
  input logic [DATA_W-1:0] dat_i,
  input logic              int_en_i,
  input logic [1:0]        ext_irq_i,
  input logic [DATA_W-1:0] dat_o,
  input logic              ack_o,
  input logic              fault_o,
  input irq_code_e         irq_code_o
);
  timeunit 1ns;
  timeprecision 100ps;

  int errors = 0;
  int checks = 0;

  logic [DATA_W-1:0] rom_m [ROM_WORDS];
  logic [DATA_W-1:0] ram_m [RAM_WORDS];
  logic [DATA_W-1:0] cmp_m [TIMERS];
  logic [DATA_W-1:0] cnt_m [TIMERS];
  logic [TIMERS-1:0] en_m;
  logic [TIMERS-1:0] pend_m;
  logic [DATA_W-1:0] exp_rd;
  chip_sel_e         cur_cs;
  logic              accepted;
  logic              acked;
  int                edges;

  initial begin
    $readmemh(ROM_FILE, rom_m);
  end

  task automatic note_error(input string msg);
    errors++;
    $display("[FAIL] %0d ns: %s", $time, msg);
  endtask

  // memory map as the address rules define it
  function automatic chip_sel_e classify(input logic [ADDR_W-1:0] a);
    int word;
    word = int'(a[11:2]);
    if (a[31:16] != 0) return cs_fault;
    if (a[15:12] == REGION_ROM && word < ROM_WORDS) return cs_rom;
    if (a[15:12] == REGION_RAM && word < RAM_WORDS) return cs_ram;
    if (a[15:12] == REGION_TIMER && word < 8) return cs_timer;
    return cs_fault;
  endfunction

  always @(posedge sysclock or posedge rst_i) begin
    logic [TIMERS-1:0] hit;
    logic [TIMERS-1:0] clr;
    logic [TIMERS-1:0] en_old;
    int w;
    if (rst_i) begin
      en_m     = '0;
      pend_m   = '0;
      accepted = 1'b0;
      acked    = 1'b0;
      edges    = 0;
      for (int i = 0; i < TIMERS; i++) begin
        cnt_m[i] = '0;
        cmp_m[i] = '0;
      end
    end else begin
      for (int i = 0; i < TIMERS; i++) begin
        hit[i] = en_m[i] && (cnt_m[i] == cmp_m[i]);
      end
      clr    = '0;
      en_old = en_m;
      if (!cyc_i) begin
        accepted = 1'b0;
        acked    = 1'b0;
        edges    = 0;
      end else if (acked) begin
        // master samples ack on this edge, a new request may follow
        accepted = 1'b0;
        acked    = 1'b0;
        edges    = 0;
      end else begin
        edges++;
        if (!accepted) begin
          accepted = 1'b1;
          cur_cs   = classify(adr_i);
          w        = int'(adr_i[11:2]);
          exp_rd   = '0;
          case (cur_cs)
            cs_rom: exp_rd = rom_m[w];
            cs_ram: begin
              exp_rd = ram_m[w];
              if (we_i) begin
                for (int b = 0; b < SEL_W; b++) begin
                  if (sel_i[b]) ram_m[w][8*b +: 8] = dat_i[8*b +: 8];
                end
              end
            end
            cs_timer: begin
              if (w < 4) exp_rd = cmp_m[w];
              else if (w == 4) exp_rd = DATA_W'(en_m);
              else if (w == 5) exp_rd = DATA_W'(pend_m);
              if (we_i && w < 4) cmp_m[w] = dat_i;
              if (we_i && w == 4) en_m = dat_i[TIMERS-1:0];
              if (we_i && w == 5) clr = dat_i[TIMERS-1:0];
            end
            default: ;
          endcase
        end
      end
      pend_m = (pend_m & ~clr) | hit;
      for (int i = 0; i < TIMERS; i++) begin
        cnt_m[i] = (!en_old[i] || hit[i]) ? '0 : cnt_m[i] + 1;
      end
    end
  end

  always @(negedge sysclock) begin
    irq_code_e exp_irq;
    int lat;
    if (!rst_i) begin
      exp_irq = irq_none;
      if (int_en_i) begin
        if (cyc_i && classify(adr_i) == cs_fault) exp_irq = irq_fault;
        else if (pend_m[3]) exp_irq = irq_timer3;
        else if (pend_m[2]) exp_irq = irq_timer2;
        else if (pend_m[1]) exp_irq = irq_timer1;
        else if (pend_m[0]) exp_irq = irq_timer0;
        else if (ext_irq_i[0]) exp_irq = irq_ext0;
        else if (ext_irq_i[1]) exp_irq = irq_ext1;
      end
      if (irq_code_o !== exp_irq) begin
        note_error($sformatf("irq code %0d, expected %0d", irq_code_o, exp_irq));
      end
      if (cyc_i && ack_o) begin
        checks++;
        lat = (cur_cs == cs_rom && !we_i) ? 2 : 1;
        if (edges != lat) begin
          note_error($sformatf("ack for %h after %0d cycles, expected %0d", adr_i, edges, lat));
        end
        if (!we_i && dat_o !== exp_rd) begin
          note_error($sformatf("read %h gave %h, expected %h", adr_i, dat_o, exp_rd));
        end
        if (fault_o !== (cur_cs == cs_fault)) begin
          note_error($sformatf("fault_o %b wrong for address %h", fault_o, adr_i));
        end
        acked = 1'b1;
      end
    end
  end

endmodule

// ==== tb/soc_bus_properties.sv ====
module soc_bus_properties (
  input logic sysclock,
  input logic rst_i,
  input logic ack_o,
  input logic fault_o,
  input logic fault_ack
);
  timeunit 1ns;
  timeprecision 100ps;

  // one ack per request
  assert property (@(posedge sysclock) disable iff (rst_i) ack_o |=> !ack_o)
    else $error("ack held for two cycles");

  assert property (@(posedge sysclock) rst_i |-> !ack_o)
    else $error("ack high during reset");

  // unmapped cycle is terminated on the next edge
  assert property (@(posedge sysclock) disable iff (rst_i)
                   fault_o && !fault_ack |=> ack_o)
    else $error("fault cycle not acknowledged");

endmodule

bind soc_bus_top soc_bus_properties props (
  .sysclock  (sysclock),
  .rst_i     (rst_i),
  .ack_o     (ack_o),
  .fault_o   (fault_o),
  .fault_ack (fault_ack)
);

// ==== logic/soc_bus_top.sv ====
module soc_bus_top import soc_pkg::*; (
  input  logic              sysclock,
  input  logic              rst_i,
  input  logic              cyc_i,
  input  logic              we_i,
  input  logic [SEL_W-1:0]  sel_i,
  input  logic [ADDR_W-1:0] adr_i,
  input  logic [DATA_W-1:0] dat_i,
  input  logic              int_en_i,
  input  logic [1:0]        ext_irq_i,
  output logic [DATA_W-1:0] dat_o,
  output logic              ack_o,
  output logic              fault_o,
  output irq_code_e         irq_code_o
);

  chip_sel_e         cs;
  logic              fault_ack;
  logic [TIMERS-1:0] tmr_pend;

  wb_if rom_bus ();
  wb_if ram_bus ();
  wb_if tmr_bus ();

  // shared request lines, strobe per slave
  assign rom_bus.cyc   = cyc_i;
  assign rom_bus.stb   = (cs == cs_rom);
  assign rom_bus.we    = we_i;
  assign rom_bus.sel   = sel_i;
  assign rom_bus.adr   = adr_i;
  assign rom_bus.dat_w = dat_i;

  assign ram_bus.cyc   = cyc_i;
  assign ram_bus.stb   = (cs == cs_ram);
  assign ram_bus.we    = we_i;
  assign ram_bus.sel   = sel_i;
  assign ram_bus.adr   = adr_i;
  assign ram_bus.dat_w = dat_i;

  assign tmr_bus.cyc   = cyc_i;
  assign tmr_bus.stb   = (cs == cs_timer);
  assign tmr_bus.we    = we_i;
  assign tmr_bus.sel   = sel_i;
  assign tmr_bus.adr   = adr_i;
  assign tmr_bus.dat_w = dat_i;

  bus_decoder decoder0 (
    .sysclock    (sysclock),
    .rst_i       (rst_i),
    .cyc_i       (cyc_i),
    .adr_i       (adr_i),
    .sel_o       (cs),
    .fault_o     (fault_o),
    .fault_ack_o (fault_ack)
  );

  boot_rom rom0 (.sysclock(sysclock), .rst_i(rst_i), .bus(rom_bus));

  scratch_ram ram0 (.sysclock(sysclock), .rst_i(rst_i), .bus(ram_bus));

  interval_timer timer0 (
    .sysclock (sysclock),
    .rst_i    (rst_i),
    .bus      (tmr_bus),
    .pend_o   (tmr_pend)
  );

  irq_priority irq0 (
    .int_en_i     (int_en_i),
    .fault_i      (fault_o),
    .timer_pend_i (tmr_pend),
    .ext_irq_i    (ext_irq_i),
    .irq_code_o   (irq_code_o)
  );

  // unmapped reads give zero
  always_comb begin
    case (cs)
      cs_rom:   dat_o = rom_bus.dat_r;
      cs_ram:   dat_o = ram_bus.dat_r;
      cs_timer: dat_o = tmr_bus.dat_r;
      default:  dat_o = '0;
    endcase
  end

  always_comb begin
    case (cs)
      cs_rom:   ack_o = rom_bus.ack;
      cs_ram:   ack_o = ram_bus.ack;
      cs_timer: ack_o = tmr_bus.ack;
      cs_fault: ack_o = fault_ack;
      default:  ack_o = 1'b0;
    endcase
  end

endmodule

// ==== logic/interval_timer.sv ====
module interval_timer import soc_pkg::*; (
  input  logic              sysclock,
  input  logic              rst_i,
  wb_if.slave               bus,
  output logic [TIMERS-1:0] pend_o
);

  logic [DATA_W-1:0] cmp_q [TIMERS];
  logic [DATA_W-1:0] cnt_q [TIMERS];
  logic [TIMERS-1:0] en_q;
  logic [TIMERS-1:0] pend_q;
  logic [TIMERS-1:0] hit;
  logic [TIMERS-1:0] clr;
  logic [DATA_W-1:0] rd_data;
  logic [DATA_W-1:0] dat_q;
  logic [TMR_AW-1:0] off;
  logic              ack_q;
  logic              access;
  logic              wr;

  assign off    = bus.adr[TMR_AW+1:2];
  assign access = bus.cyc & bus.stb & ~ack_q;
  assign wr     = access & bus.we;

  always_comb begin
    for (int i = 0; i < TIMERS; i++) begin
      hit[i] = en_q[i] && (cnt_q[i] == cmp_q[i]);
    end
  end

  // write one to clear
  assign clr = (wr && off == TMR_STAT) ? bus.dat_w[TIMERS-1:0] : '0;

  always_comb begin
    case (off)
      TMR_CMP0, TMR_CMP1, TMR_CMP2, TMR_CMP3: rd_data = cmp_q[off[1:0]];
      TMR_CTRL: rd_data = DATA_W'(en_q);
      TMR_STAT: rd_data = DATA_W'(pend_q);
      default:  rd_data = '0;
    endcase
  end

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      en_q  <= '0;
      for (int i = 0; i < TIMERS; i++) begin
        cmp_q[i] <= '0;
      end
    end else begin
      ack_q <= access;
      if (wr) begin
        case (off)
          TMR_CMP0, TMR_CMP1, TMR_CMP2, TMR_CMP3: cmp_q[off[1:0]] <= bus.dat_w;
          TMR_CTRL: en_q <= bus.dat_w[TIMERS-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      pend_q <= '0;
      for (int i = 0; i < TIMERS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      // a new hit beats a clear in the same cycle
      pend_q <= (pend_q & ~clr) | hit;
      for (int i = 0; i < TIMERS; i++) begin
        if (!en_q[i] || hit[i]) begin
          cnt_q[i] <= '0;
        end else begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge sysclock) begin
    if (access) begin
      dat_q <= rd_data;
    end
  end

  assign bus.dat_r = dat_q;
  assign bus.ack   = ack_q;
  assign pend_o    = pend_q;

endmodule

// ==== logic/scratch_ram.sv ====
module scratch_ram import soc_pkg::*; (
  input logic sysclock,
  input logic rst_i,
  wb_if.slave bus
);

  logic [DATA_W-1:0] mem [RAM_WORDS];
  logic [RAM_AW-1:0] idx;
  logic [DATA_W-1:0] dat_q;
  logic              ack_q;
  logic              access;

  assign idx = bus.adr[RAM_AW+1:2];

  // accepted once per request, on the edge that raises ack
  assign access = bus.cyc & bus.stb & ~ack_q;

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge sysclock) begin
    if (access) begin
      if (bus.we) begin
        // per byte lane
        for (int i = 0; i < SEL_W; i++) begin
          if (bus.sel[i]) begin
            mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
          end
        end
      end
      dat_q <= mem[idx];
    end
  end

  assign bus.dat_r = dat_q;
  assign bus.ack   = ack_q;

endmodule

// ==== logic/boot_rom.sv ====
module boot_rom import soc_pkg::*; (
  input logic sysclock,
  input logic rst_i,
  wb_if.slave bus
);

  logic [DATA_W-1:0] mem [ROM_WORDS];
  logic [ROM_AW-1:0] adr_q;
  logic [DATA_W-1:0] dat_q;
  logic [1:0]        rd_pipe;
  logic              wr_ack;
  logic              req;
  logic              rd_req;

  initial begin
    $readmemh(ROM_FILE, mem);
  end

  assign req = bus.cyc & bus.stb;
  // one read per request, held off until the pipe has drained
  assign rd_req = req & ~bus.we & ~|rd_pipe;

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      rd_pipe <= 2'b00;
      wr_ack  <= 1'b0;
    end else if (!bus.stb) begin
      rd_pipe <= 2'b00;
      wr_ack  <= 1'b0;
    end else begin
      rd_pipe <= {rd_pipe[0], rd_req};
      // writes are dropped, just acknowledged
      wr_ack  <= req & bus.we & ~wr_ack;
    end
  end

  always_ff @(posedge sysclock) begin
    if (rd_req) begin
      adr_q <= bus.adr[ROM_AW+1:2];
    end
    dat_q <= mem[adr_q];
  end

  assign bus.dat_r = dat_q;
  assign bus.ack   = rd_pipe[1] | wr_ack;

endmodule

// ==== logic/irq_priority.sv ====
module irq_priority import soc_pkg::*; (
  input  logic              int_en_i,
  input  logic              fault_i,
  input  logic [TIMERS-1:0] timer_pend_i,
  input  logic [1:0]        ext_irq_i,
  output irq_code_e         irq_code_o
);

  // fault first, then timers high to low, then external lines
  always_comb begin
    irq_code_o = irq_none;
    if (int_en_i) begin
      if (fault_i) begin
        irq_code_o = irq_fault;
      end else if (timer_pend_i[3]) begin
        irq_code_o = irq_timer3;
      end else if (timer_pend_i[2]) begin
        irq_code_o = irq_timer2;
      end else if (timer_pend_i[1]) begin
        irq_code_o = irq_timer1;
      end else if (timer_pend_i[0]) begin
        irq_code_o = irq_timer0;
      end else if (ext_irq_i[0]) begin
        irq_code_o = irq_ext0;
      end else if (ext_irq_i[1]) begin
        irq_code_o = irq_ext1;
      end
    end
  end

endmodule

// ==== logic/bus_decoder.sv ====
module bus_decoder import soc_pkg::*; (
  input  logic              sysclock,
  input  logic              rst_i,
  input  logic              cyc_i,
  input  logic [ADDR_W-1:0] adr_i,
  output chip_sel_e         sel_o,
  output logic              fault_o,
  output logic              fault_ack_o
);

  always_comb begin
    sel_o = cs_none;
    if (cyc_i) begin
      // anything not matched below is a fault
      sel_o = cs_fault;
      if (adr_i[ADDR_W-1:16] == '0) begin
        case (adr_i[15:12])
          REGION_ROM:   if (adr_i[11:ROM_AW+2] == '0) sel_o = cs_rom;
          REGION_RAM:   if (adr_i[11:RAM_AW+2] == '0) sel_o = cs_ram;
          REGION_TIMER: if (adr_i[11:TMR_AW+2] == '0) sel_o = cs_timer;
          default: ;
        endcase
      end
    end
  end

  assign fault_o = (sel_o == cs_fault);

  // terminate unmapped cycles so the master never hangs
  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      fault_ack_o <= 1'b0;
    end else begin
      fault_ack_o <= fault_o & ~fault_ack_o;
    end
  end

endmodule

// ==== logic/soc_pkg.sv ====
package soc_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SEL_W  = 4;

  // memory depths and word-index widths
  localparam int ROM_WORDS = 16;
  localparam int RAM_WORDS = 64;
  localparam int ROM_AW    = $clog2(ROM_WORDS);
  localparam int RAM_AW    = $clog2(RAM_WORDS);
  localparam int TMR_AW    = 3;

  // region is address bits 15:12, upper half must be zero
  localparam logic [3:0] REGION_ROM   = 4'd0;
  localparam logic [3:0] REGION_RAM   = 4'd1;
  localparam logic [3:0] REGION_TIMER = 4'd2;

  typedef enum logic [2:0] {
    cs_none,
    cs_rom,
    cs_ram,
    cs_timer,
    cs_fault
  } chip_sel_e;

  typedef enum logic [2:0] {
    irq_none   = 3'd0,
    irq_fault  = 3'd1,
    irq_timer0 = 3'd2,
    irq_timer1 = 3'd3,
    irq_timer2 = 3'd4,
    irq_timer3 = 3'd5,
    irq_ext0   = 3'd6,
    irq_ext1   = 3'd7
  } irq_code_e;

  // timer word offsets
  localparam int TIMERS = 4;
  localparam logic [TMR_AW-1:0] TMR_CMP0 = 3'd0;
  localparam logic [TMR_AW-1:0] TMR_CMP1 = 3'd1;
  localparam logic [TMR_AW-1:0] TMR_CMP2 = 3'd2;
  localparam logic [TMR_AW-1:0] TMR_CMP3 = 3'd3;
  localparam logic [TMR_AW-1:0] TMR_CTRL = 3'd4;
  localparam logic [TMR_AW-1:0] TMR_STAT = 3'd5;

  localparam string ROM_FILE = "rom_init.hex";

endpackage

interface wb_if import soc_pkg::*; ();
  logic              cyc;
  logic              stb;
  logic              we;
  logic [SEL_W-1:0]  sel;
  logic [ADDR_W-1:0] adr;
  logic [DATA_W-1:0] dat_w;
  logic [DATA_W-1:0] dat_r;
  logic              ack;

  modport master (output cyc, stb, we, sel, adr, dat_w, input dat_r, ack);
  modport slave  (input cyc, stb, we, sel, adr, dat_w, output dat_r, ack);
endinterface
